/* hdl/clock_pkg.sv */
// clock package
// shared field types, limits, reset values and the seven-segment
// pattern table for the alarm clock
package clock_pkg;

   ///////////////////////////////
   // limits and reset values
   ///////////////////////////////
   localparam int NUM_DIGITS = 8;

   // minute or second count, 0..59
   typedef logic [5:0] min_sec_t;
   // hour count, 0..23
   typedef logic [4:0] hour_t;
   // segments a..g, active low, a is the msb
   typedef logic [6:0] seg_t;
   // digit enables, active low
   typedef logic [NUM_DIGITS-1:0] anode_t;

   localparam min_sec_t MAX_MIN_SEC = 6'd59;
   localparam hour_t MAX_HOUR = 5'd23;
   localparam hour_t ALARM_RESET_HR = 5'd12;

   // set-mode field selector, wraps after the alarm hour
   typedef enum logic [1:0] {
      FIELD_MIN,
      FIELD_HR,
      FIELD_ALM_MIN,
      FIELD_ALM_HR
   } field_t;

   ///////////////////////////////
   // segment patterns
   ///////////////////////////////
   function automatic seg_t digit_to_seg(input logic [3:0] digit);
      case (digit)
         4'd1: return 7'b1001111;
         4'd2: return 7'b0010010;
         4'd3: return 7'b0000110;
         4'd4: return 7'b1001100;
         4'd5: return 7'b0100100;
         4'd6: return 7'b0100000;
         4'd7: return 7'b0001111;
         4'd8: return 7'b0000000;
         4'd9: return 7'b0000100;
         // zero, and anything out of range shows as zero
         default: return 7'b0000001;
      endcase
   endfunction

endpackage

/* hdl/time_if.sv */
// time interface
// current time, alarm setting, set mode and blink phase, shared by
// the time keeper, the display and the alarm
`timescale 1ns/1ps

interface time_if (input logic clk);

   clock_pkg::min_sec_t sec;
   clock_pkg::min_sec_t min;
   clock_pkg::min_sec_t alm_min;
   clock_pkg::hour_t    hr;
   clock_pkg::hour_t    alm_hr;
   logic                set_mode;
   // high in the first half of each second
   logic                blink;

   modport keeper (input clk,
                   output sec, min, hr, alm_min, alm_hr, set_mode, blink);

   modport display (input min, hr, alm_min, alm_hr, blink);

   modport alarm (input min, hr, alm_min, alm_hr, set_mode);

endinterface

/* hdl/time_keeper.sv */
// time keeper
// one-second prescaler, seconds/minutes/hours with carry, and the
// set-mode editor for time and alarm fields
`timescale 1ns/1ps

module time_keeper #(
   parameter int TICKS_PER_SEC = 50_000_000
) (
   input  logic  clk,
   input  logic  rst,
   input  logic  set1,
   input  logic  tg,
   input  logic  inc,
   input  logic  dec,
   time_if.keeper tif
);

   localparam int CNT_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;

   logic [CNT_W-1:0]  presc;
   logic              tick;
   clock_pkg::field_t field_sel;

   // one step up or down with wrap, hours share the 6 bit path
   function automatic clock_pkg::min_sec_t step_wrap(input clock_pkg::min_sec_t value,
                                                     input clock_pkg::min_sec_t max_value,
                                                     input logic up);
      if (up) begin
         return (value == max_value) ? '0 : value + 6'd1;
      end
      return (value == '0) ? max_value : value - 6'd1;
   endfunction

   //////////////////////////////
   // prescaler
   //////////////////////////////
   assign tick      = (presc == CNT_W'(TICKS_PER_SEC - 1));
   assign tif.blink = (presc < CNT_W'(TICKS_PER_SEC / 2));

   always_ff @(posedge clk) begin
      if (rst) begin
         presc <= '0;
      end else if (tick) begin
         presc <= '0;
      end else begin
         presc <= presc + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         tif.set_mode <= 1'b0;
      end else begin
         tif.set_mode <= set1;
      end
   end

   //////////////////////////////
   // counters and field editor
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         tif.sec     <= '0;
         tif.min     <= '0;
         tif.hr      <= '0;
         tif.alm_min <= '0;
         tif.alm_hr  <= clock_pkg::ALARM_RESET_HR;
         field_sel   <= clock_pkg::FIELD_MIN;
      end else if (tick) begin
         if (!tif.set_mode) begin
            // normal run, 23:59:59 rolls over to midnight
            if (tif.sec == clock_pkg::MAX_MIN_SEC) begin
               tif.sec <= '0;
               if (tif.min == clock_pkg::MAX_MIN_SEC) begin
                  tif.min <= '0;
                  tif.hr  <= (tif.hr == clock_pkg::MAX_HOUR) ? '0 : tif.hr + 5'd1;
               end else begin
                  tif.min <= tif.min + 6'd1;
               end
            end else begin
               tif.sec <= tif.sec + 6'd1;
            end
         end else begin
            // seconds hold while setting; inc beats dec
            if (inc || dec) begin
               case (field_sel)
                  clock_pkg::FIELD_MIN:
                     tif.min <= step_wrap(tif.min, clock_pkg::MAX_MIN_SEC, inc);
                  clock_pkg::FIELD_HR:
                     tif.hr <= clock_pkg::hour_t'(step_wrap(
                        clock_pkg::min_sec_t'(tif.hr),
                        clock_pkg::min_sec_t'(clock_pkg::MAX_HOUR), inc));
                  clock_pkg::FIELD_ALM_MIN:
                     tif.alm_min <= step_wrap(tif.alm_min, clock_pkg::MAX_MIN_SEC, inc);
                  default:
                     tif.alm_hr <= clock_pkg::hour_t'(step_wrap(
                        clock_pkg::min_sec_t'(tif.alm_hr),
                        clock_pkg::min_sec_t'(clock_pkg::MAX_HOUR), inc));
               endcase
            end
            // the edit above still lands on the old field
            if (tg) begin
               field_sel <= clock_pkg::field_t'(field_sel + 2'd1);
            end
         end
      end
   end

endmodule

/* hdl/seg_display.sv */
// seven-segment scan display
// cycles through eight digits, time on 0..3 and alarm on 4..7,
// with a blinking decimal point on digits 2 and 6
`timescale 1ns/1ps

module seg_display #(
   parameter int SCAN_TICKS = 2000
) (
   input  logic                   clk,
   input  logic                   rst,
   time_if.display                tif,
   output clock_pkg::seg_t        seg,
   output clock_pkg::anode_t      an,
   output logic                   dp
);

   localparam int SCAN_W = (SCAN_TICKS > 1) ? $clog2(SCAN_TICKS) : 1;
   localparam int IDX_W  = $clog2(clock_pkg::NUM_DIGITS);

   logic [SCAN_W-1:0] scan_cnt;
   logic [IDX_W-1:0]  digit_idx;
   logic [7:0]        min_bcd;
   logic [7:0]        hr_bcd;
   logic [7:0]        alm_min_bcd;
   logic [7:0]        alm_hr_bcd;
   logic [3:0]        digit_val;
   logic              dp_digit;

   // tens in the upper nibble, ones in the lower
   function automatic logic [7:0] split_bcd(input clock_pkg::min_sec_t value);
      logic [3:0] tens;
      logic [3:0] ones;
      tens = 4'(value / 6'd10);
      ones = 4'(value % 6'd10);
      return {tens, ones};
   endfunction

   //////////////////////////////
   // scan timing
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         scan_cnt  <= '0;
         digit_idx <= '0;
      end else if (scan_cnt == SCAN_W'(SCAN_TICKS - 1)) begin
         scan_cnt <= '0;
         if (digit_idx == IDX_W'(clock_pkg::NUM_DIGITS - 1)) begin
            digit_idx <= '0;
         end else begin
            digit_idx <= digit_idx + 1'b1;
         end
      end else begin
         scan_cnt <= scan_cnt + 1'b1;
      end
   end

   //////////////////////////////
   // digit select
   //////////////////////////////
   assign min_bcd     = split_bcd(tif.min);
   assign hr_bcd      = split_bcd(clock_pkg::min_sec_t'(tif.hr));
   assign alm_min_bcd = split_bcd(tif.alm_min);
   assign alm_hr_bcd  = split_bcd(clock_pkg::min_sec_t'(tif.alm_hr));

   always_comb begin
      case (digit_idx)
         3'd0:    digit_val = min_bcd[3:0];
         3'd1:    digit_val = min_bcd[7:4];
         3'd2:    digit_val = hr_bcd[3:0];
         3'd3:    digit_val = hr_bcd[7:4];
         3'd4:    digit_val = alm_min_bcd[3:0];
         3'd5:    digit_val = alm_min_bcd[7:4];
         3'd6:    digit_val = alm_hr_bcd[3:0];
         default: digit_val = alm_hr_bcd[7:4];
      endcase
   end

   // hour ones digits carry the blinking point
   assign dp_digit = (digit_idx == 3'd2) || (digit_idx == 3'd6);

   // output registers, one cycle behind the index
   always_ff @(posedge clk) begin
      if (rst) begin
         an  <= '1;
         seg <= '1;
         dp  <= 1'b1;
      end else begin
         an  <= ~(clock_pkg::anode_t'(1) << digit_idx);
         seg <= clock_pkg::digit_to_seg(digit_val);
         dp  <= ~(dp_digit && tif.blink);
      end
   end

endmodule

/* hdl/alarm_buzzer.sv */
// alarm and buzzer
// flags a time/alarm match outside set mode and drives a square tone
`timescale 1ns/1ps

module alarm_buzzer #(
   parameter int TONE_HALF_PERIOD = 28409
) (
   input  logic  clk,
   input  logic  rst,
   time_if.alarm tif,
   output logic  ld,
   output logic  pwm,
   output logic  sd
);

   localparam int TONE_W = (TONE_HALF_PERIOD > 1) ? $clog2(TONE_HALF_PERIOD) : 1;

   logic              match;
   logic              sounding;
   logic [TONE_W-1:0] tone_cnt;

   assign match = !tif.set_mode && (tif.hr == tif.alm_hr) && (tif.min == tif.alm_min);

   always_ff @(posedge clk) begin
      if (rst) begin
         ld <= 1'b0;
      end else begin
         ld <= match;
      end
   end

   // amplifier on with the lamp
   assign sd = ld;

   //////////////////////////////
   // tone generator
   //////////////////////////////
   // drop pwm together with ld when the match goes away
   assign sounding = ld && match;

   always_ff @(posedge clk) begin
      if (rst || !sounding) begin
         tone_cnt <= TONE_W'(TONE_HALF_PERIOD - 1);
         pwm      <= 1'b0;
      end else if (tone_cnt == '0) begin
         tone_cnt <= TONE_W'(TONE_HALF_PERIOD - 1);
         pwm      <= ~pwm;
      end else begin
         tone_cnt <= tone_cnt - 1'b1;
      end
   end

endmodule

/* hdl/clock_top.sv */
// alarm clock top level
// 24-hour clock with one alarm, eight-digit scanned display and a
// square-wave buzzer output
`timescale 1ns/1ps

module clock_top #(
   parameter int TICKS_PER_SEC    = 50_000_000,
   parameter int SCAN_TICKS       = 2000,
   parameter int TONE_HALF_PERIOD = 28409
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              set1,
   input  logic              tg,
   input  logic              inc,
   input  logic              dec,
   output clock_pkg::seg_t   seg,
   output clock_pkg::anode_t an,
   output logic              dp,
   output logic              ld,
   output logic              pwm,
   output logic              sd
);

   time_if tif (.clk(clk));

   // counters and button handling
   time_keeper #(
      .TICKS_PER_SEC(TICKS_PER_SEC)
   ) keeper0 (
      .clk (clk),
      .rst (rst),
      .set1(set1),
      .tg  (tg),
      .inc (inc),
      .dec (dec),
      .tif (tif)
   );

   seg_display #(
      .SCAN_TICKS(SCAN_TICKS)
   ) display0 (
      .clk(clk),
      .rst(rst),
      .tif(tif),
      .seg(seg),
      .an (an),
      .dp (dp)
   );

   alarm_buzzer #(
      .TONE_HALF_PERIOD(TONE_HALF_PERIOD)
   ) alarm0 (
      .clk(clk),
      .rst(rst),
      .tif(tif),
      .ld (ld),
      .pwm(pwm),
      .sd (sd)
   );

endmodule

/* tests/clock_checker.sv */
// clock checker
// concurrent rules on the scan anodes, lamp and buzzer outputs
`timescale 1ns/1ps

module clock_checker (
   input logic              clk,
   input logic              rst,
   input logic              set1,
   input clock_pkg::anode_t an,
   input logic              ld,
   input logic              pwm,
   input logic              sd
);

   // one digit at a time, or all dark
   an_one_digit: assert property (@(posedge clk) disable iff (rst)
      $onehot(~an) || (an == '1))
      else $error("more than one digit enabled at once");

   sd_follows_ld: assert property (@(posedge clk) disable iff (rst)
      sd == ld)
      else $error("amplifier enable differs from the alarm lamp");

   pwm_quiet: assert property (@(posedge clk) disable iff (rst)
      !sd |-> !pwm)
      else $error("tone active with the amplifier off");

   // set mode register plus the lamp register
   set_silences: assert property (@(posedge clk) disable iff (rst)
      set1 |-> ##2 !ld)
      else $error("alarm lamp still lit two cycles after set mode");

endmodule

bind clock_top clock_checker checker0 (
   .clk (clk),
   .rst (rst),
   .set1(set1),
   .an  (an),
   .ld  (ld),
   .pwm (pwm),
   .sd  (sd)
);

/* tests/clock_top_tb.sv */
// alarm clock testbench
// walks a table of button settings through set mode, timekeeping and
// the alarm, reading the scanned display back after every row
`timescale 1ns/1ps

module clock_top_tb;

   localparam int CLK_PERIOD       = 20;
   localparam int TICKS_PER_SEC    = 40;
   localparam int SCAN_TICKS       = 2;
   localparam int TONE_HALF_PERIOD = 3;
   localparam int HALF_SEC         = TICKS_PER_SEC / 2;
   localparam int FRAME_CYCLES     = 8 * SCAN_TICKS + 1;
   localparam int FRAME_SAMPLES    = FRAME_CYCLES + 1;
   localparam int NUM_ROWS         = 24;

   // buttons, seconds to hold them, then the expected display and lamp
   typedef struct {
      int set1;
      int tg;
      int inc;
      int dec;
      int secs;
      int mm;
      int hh;
      int alm_mm;
      int alm_hh;
      int ld;
   } row_t;

   logic              clk = 1'b0;
   logic              rst;
   logic              set1, tg, inc, dec;
   clock_pkg::seg_t   seg;
   clock_pkg::anode_t an;
   logic              dp, ld, pwm, sd;

   row_t       rows [NUM_ROWS];
   int         shown [8];
   logic       last_ld, last_sd, last_pwm;
   int         checks = 0;
   int         errors = 0;
   int         monitor_errors = 0;
   int         tone_checks = 0;
   // {digit 6 high, digit 6 low, digit 2 high, digit 2 low}
   logic [3:0] dp_seen = '0;
   longint     cycle_cnt = 0;
   longint     last_pwm_edge = -1;
   logic       prev_pwm = 1'b0;

   clock_top #(
      .TICKS_PER_SEC   (TICKS_PER_SEC),
      .SCAN_TICKS      (SCAN_TICKS),
      .TONE_HALF_PERIOD(TONE_HALF_PERIOD)
   ) dut0 (
      .clk (clk),
      .rst (rst),
      .set1(set1),
      .tg  (tg),
      .inc (inc),
      .dec (dec),
      .seg (seg),
      .an  (an),
      .dp  (dp),
      .ld  (ld),
      .pwm (pwm),
      .sd  (sd)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic load_table();
      // set mode edits: dec from zero, inc over dec, tg after the edit
      rows[0]  = '{1, 0, 0, 1, 1, 59, 0, 0, 12, 0};
      rows[1]  = '{1, 0, 1, 0, 2, 1, 0, 0, 12, 0};
      rows[2]  = '{1, 1, 1, 1, 1, 2, 0, 0, 12, 0};
      rows[3]  = '{1, 0, 0, 1, 1, 2, 23, 0, 12, 0};
      rows[4]  = '{1, 1, 1, 0, 1, 2, 0, 0, 12, 0};
      rows[5]  = '{1, 0, 0, 1, 1, 2, 0, 59, 12, 0};
      rows[6]  = '{1, 1, 1, 0, 1, 2, 0, 0, 12, 0};
      rows[7]  = '{1, 0, 0, 1, 2, 2, 0, 0, 10, 0};
      rows[8]  = '{1, 1, 0, 0, 1, 2, 0, 0, 10, 0};
      // 23:59 then one minute of running
      rows[9]  = '{1, 0, 0, 1, 3, 59, 0, 0, 10, 0};
      rows[10] = '{1, 1, 0, 0, 1, 59, 0, 0, 10, 0};
      rows[11] = '{1, 1, 0, 1, 1, 59, 23, 0, 10, 0};
      rows[12] = '{0, 0, 0, 0, 60, 0, 0, 0, 10, 0};
      rows[13] = '{1, 1, 0, 0, 2, 0, 0, 0, 10, 0};
      rows[14] = '{1, 0, 1, 0, 5, 5, 0, 0, 10, 0};
      rows[15] = '{0, 0, 0, 0, 60, 6, 0, 0, 10, 0};
      // alarm to 00:06, sound it, silence it twice
      rows[16] = '{1, 1, 0, 0, 2, 6, 0, 0, 10, 0};
      rows[17] = '{1, 0, 1, 0, 6, 6, 0, 6, 10, 0};
      rows[18] = '{1, 1, 0, 0, 1, 6, 0, 6, 10, 0};
      rows[19] = '{1, 0, 0, 1, 10, 6, 0, 6, 0, 0};
      rows[20] = '{0, 0, 0, 0, 2, 6, 0, 6, 0, 1};
      rows[21] = '{1, 0, 0, 0, 1, 6, 0, 6, 0, 0};
      rows[22] = '{0, 0, 0, 0, 1, 6, 0, 6, 0, 1};
      rows[23] = '{0, 0, 0, 0, 57, 7, 0, 6, 0, 0};
   endtask

   //////////////////////////////
   // display readback
   //////////////////////////////
   function automatic int seg_to_digit(input clock_pkg::seg_t pattern);
      case (pattern)
         7'b0000001: return 0;
         7'b1001111: return 1;
         7'b0010010: return 2;
         7'b0000110: return 3;
         7'b1001100: return 4;
         7'b0100100: return 5;
         7'b0100000: return 6;
         7'b0001111: return 7;
         7'b0000000: return 8;
         7'b0000100: return 9;
         default:    return -1;
      endcase
   endfunction

   // position of the single low anode, -1 when none or several
   function automatic int anode_index(input clock_pkg::anode_t value);
      int idx;
      int zeros;
      idx = -1;
      zeros = 0;
      for (int i = 0; i < 8; i++) begin
         if (!value[i]) begin
            idx = i;
            zeros++;
         end
      end
      return (zeros == 1) ? idx : -1;
   endfunction

   task automatic read_frame();
      int idx;
      for (int i = 0; i < 8; i++) begin
         shown[i] = -1;
      end
      repeat (FRAME_SAMPLES) begin
         @(negedge clk);
         idx = anode_index(an);
         if (idx >= 0) begin
            shown[idx] = seg_to_digit(seg);
         end
      end
      last_ld  = ld;
      last_sd  = sd;
      last_pwm = pwm;
      @(posedge clk);
   endtask

   task automatic check_display(input int row, input row_t exp);
      int expect_digits [8];
      expect_digits[0] = exp.mm % 10;
      expect_digits[1] = exp.mm / 10;
      expect_digits[2] = exp.hh % 10;
      expect_digits[3] = exp.hh / 10;
      expect_digits[4] = exp.alm_mm % 10;
      expect_digits[5] = exp.alm_mm / 10;
      expect_digits[6] = exp.alm_hh % 10;
      expect_digits[7] = exp.alm_hh / 10;
      read_frame();
      for (int i = 0; i < 8; i++) begin
         checks++;
         assert (shown[i] == expect_digits[i]) else begin
            $display("ERROR: row %0d seg on digit %0d reads %0h, expected %0h",
                     row, i, shown[i], expect_digits[i]);
            errors++;
         end
      end
      checks += 3;
      assert (int'(last_ld) == exp.ld) else begin
         $display("ERROR: row %0d ld = %0h, expected %0h", row, last_ld, exp.ld);
         errors++;
      end
      assert (int'(last_sd) == exp.ld) else begin
         $display("ERROR: row %0d sd = %0h, expected %0h", row, last_sd, exp.ld);
         errors++;
      end
      assert (exp.ld != 0 || last_pwm == 1'b0) else begin
         $display("ERROR: row %0d pwm = %0h, expected %0h", row, last_pwm, 1'b0);
         errors++;
      end
   endtask

   task automatic apply_row(input int r);
      set1 <= (rows[r].set1 != 0);
      tg   <= (rows[r].tg != 0);
      inc  <= (rows[r].inc != 0);
      dec  <= (rows[r].dec != 0);
      // rows start mid-second, so the last tick lands half a second before the end
      repeat (rows[r].secs * TICKS_PER_SEC - HALF_SEC) @(posedge clk);
      check_display(r, rows[r]);
      repeat (HALF_SEC - FRAME_SAMPLES) @(posedge clk);
   endtask

   //////////////////////////////
   // decimal point and tone watch
   //////////////////////////////
   always @(negedge clk) begin
      int idx;
      cycle_cnt++;
      idx = anode_index(an);
      if (!rst && idx >= 0) begin
         if (idx == 2 || idx == 6) begin
            dp_seen[{idx == 6, dp}] = 1'b1;
         end else begin
            assert (dp == 1'b1) else begin
               $display("ERROR: dp = %0h on digit %0d, expected %0h", dp, idx, 1'b1);
               monitor_errors++;
            end
         end
      end
      if (rst || !ld) begin
         last_pwm_edge = -1;
      end else if (pwm != prev_pwm) begin
         if (last_pwm_edge >= 0) begin
            tone_checks++;
            assert (cycle_cnt - last_pwm_edge == longint'(TONE_HALF_PERIOD)) else begin
               $display("ERROR: pwm half period = %0h cycles, expected %0h",
                        cycle_cnt - last_pwm_edge, TONE_HALF_PERIOD);
               monitor_errors++;
            end
         end
         last_pwm_edge = cycle_cnt;
      end
      prev_pwm = pwm;
   end

   initial begin
      row_t reset_row;
      rst  <= 1'b1;
      set1 <= 1'b0;
      tg   <= 1'b0;
      inc  <= 1'b0;
      dec  <= 1'b0;
      load_table();
      reset_row = '{0, 0, 0, 0, 0, 0, 0, 0, 12, 0};
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      // straight out of reset, inside the first half second
      check_display(-1, reset_row);
      repeat (HALF_SEC - FRAME_SAMPLES) @(posedge clk);
      for (int r = 0; r < NUM_ROWS; r++) begin
         apply_row(r);
      end
      checks += 2;
      assert (dp_seen == 4'b1111) else begin
         $display("decimal point was not seen both lit and dark on digits 2 and 6");
         errors++;
      end
      assert (tone_checks > 0) else begin
         $display("no tone half period was measured while the alarm sounded");
         errors++;
      end
      $display("checks: %0d, errors: %0d, monitor errors: %0d, tone periods: %0d",
               checks, errors, monitor_errors, tone_checks);
      if (errors == 0 && monitor_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // watchdog sized from the table's total hold time
   initial begin
      longint total_secs;
      longint limit_ns;
      #1;
      total_secs = 0;
      foreach (rows[i]) begin
         total_secs += rows[i].secs;
      end
      limit_ns = total_secs * TICKS_PER_SEC * CLK_PERIOD + 10 * FRAME_CYCLES * CLK_PERIOD;
      #(limit_ns);
      $display("watchdog expired after %0d ns without the run finishing", limit_ns);
      $display("Test failed");
      $finish;
   end

endmodule

/* filelist.f */
hdl/clock_pkg.sv
hdl/time_if.sv
hdl/time_keeper.sv
hdl/seg_display.sv
hdl/alarm_buzzer.sv
hdl/clock_top.sv
tests/clock_checker.sv
tests/clock_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the alarm clock testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f filelist.f \
   --top-module clock_top_tb -Mdir "$BUILD_DIR" -o clock_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/clock_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
